// ==== rtl/csr_pkg.sv ====
// Machine CSR definitions

package csr_pkg;

    localparam int unsigned XLEN = 32;

    ////////////////////////////////////////////////////////////
    // CSR addresses
    ////////////////////////////////////////////////////////////

    typedef enum logic [11:0] {
        MSTATUS   = 12'h300,
        MISA      = 12'h301,
        MIE       = 12'h304,
        MTVEC     = 12'h305,
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,
        MCAUSE    = 12'h342,
        MTVAL     = 12'h343,
        MIP       = 12'h344,
        MCYCLE    = 12'hB00,
        MINSTRET  = 12'hB02,
        MCYCLEH   = 12'hB80,
        MINSTRETH = 12'hB82,
        CYCLE     = 12'hC00,     // User-level aliases, read only
        INSTRET   = 12'hC02,
        CYCLEH    = 12'hC80,
        INSTRETH  = 12'hC82,
        MVENDORID = 12'hF11,
        MARCHID   = 12'hF12,
        MIMPID    = 12'hF13,
        MHARTID   = 12'hF14
    } csr_addr_e;

    // Low bits of the CSR funct3 field
    typedef enum logic [1:0] {
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [4:0] {
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        ECALL_FROM_UMODE    = 5'd8,
        ECALL_FROM_MMODE    = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        IRQ_NONE  = 5'd0,
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    ////////////////////////////////////////////////////////////
    // Write masks and mstatus fields
    ////////////////////////////////////////////////////////////

    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;  // MIE, MPIE, MPP
    localparam logic [XLEN-1:0] MIE_WMASK     = 32'h0000_0888;  // MSIE, MTIE, MEIE
    localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] FULL_WMASK    = 32'hFFFF_FFFF;

    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned MSTATUS_MPP_LSB  = 11;

endpackage

// ==== rtl/csr_wdata.sv ====
// CSR write data stage
`timescale 1ns/1ns

module csr_wdata (
    input  logic [11:0]              address_i,
    input  csr_pkg::csr_op_e         operation_i,
    input  logic [csr_pkg::XLEN-1:0] data_i,
    input  logic [csr_pkg::XLEN-1:0] cur_val_i,
    input  logic                     write_enable_i,
    input  logic                     killed_i,
    input  logic                     machine_return_i,
    input  logic                     raise_exception_i,
    input  logic                     interrupt_ack_i,
    output logic [csr_pkg::XLEN-1:0] wr_data_o,
    output logic                     wr_en_o
);
    import csr_pkg::*;

    csr_addr_e       csr;
    logic [XLEN-1:0] wmask;

    assign csr = csr_addr_e'(address_i);

    // Per-address mask table
    always_comb begin
        case (csr)
            MSTATUS:   wmask = MSTATUS_WMASK;
            MIE:       wmask = MIE_WMASK;
            MTVEC:     wmask = MTVEC_WMASK;
            MEPC:      wmask = MEPC_WMASK;
            MSCRATCH,
            MCAUSE,
            MTVAL,
            MCYCLE,
            MCYCLEH,
            MINSTRET,
            MINSTRETH: wmask = FULL_WMASK;
            default:   wmask = '0;       // Read-only or unknown
        endcase
    end

    always_comb begin
        case (operation_i)
            SET:     wr_data_o = (cur_val_i | data_i) & wmask;
            CLEAR:   wr_data_o = (cur_val_i & ~data_i) & wmask;
            default: wr_data_o = data_i & wmask;
        endcase
    end

    // Traps own the registers in this cycle
    assign wr_en_o = write_enable_i && !killed_i && !machine_return_i
                     && !raise_exception_i && !interrupt_ack_i;

endmodule

// ==== rtl/csr_trap_regs.sv ====
// Machine trap state registers
`timescale 1ns/1ns

module csr_trap_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [11:0]              address_i,
    input  logic [csr_pkg::XLEN-1:0] wr_data_i,
    input  logic                     wr_en_i,
    input  logic                     machine_return_i,
    input  logic                     raise_exception_i,
    input  csr_pkg::exc_code_e       exception_code_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic [csr_pkg::XLEN-1:0] instruction_i,
    input  logic                     jump_i,
    input  logic [csr_pkg::XLEN-1:0] jump_target_i,
    input  logic                     interrupt_ack_i,
    input  csr_pkg::irq_code_e       irq_code_i,
    output logic [csr_pkg::XLEN-1:0] mstatus_o,
    output logic [csr_pkg::XLEN-1:0] mie_o,
    output logic [csr_pkg::XLEN-1:0] mtvec_o,
    output logic [csr_pkg::XLEN-1:0] mscratch_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic [csr_pkg::XLEN-1:0] mcause_o,
    output logic [csr_pkg::XLEN-1:0] mtval_o,
    output csr_pkg::priv_e           privilege_o,
    output logic                     mstatus_mie_o
);
    import csr_pkg::*;

    csr_addr_e  csr;
    logic       mstatus_mie;
    logic       mstatus_mpie;
    logic [1:0] mstatus_mpp;    // Raw field, U or M in practice

    assign csr           = csr_addr_e'(address_i);
    assign mstatus_mie_o = mstatus_mie;

    // Kept fields only, the rest of mstatus reads zero
    always_comb begin
        mstatus_o                         = '0;
        mstatus_o[MSTATUS_MIE_BIT]        = mstatus_mie;
        mstatus_o[MSTATUS_MPIE_BIT]       = mstatus_mpie;
        mstatus_o[MSTATUS_MPP_LSB +: 2]   = mstatus_mpp;
    end

    ////////////////////////////////////////////////////////////
    // Update priority: mret, exception, interrupt, CSR write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= 2'b00;
            mie_o        <= '0;
            mtvec_o      <= '0;
            mscratch_o   <= '0;
            mepc_o       <= '0;
            mcause_o     <= '0;
            mtval_o      <= '0;
            privilege_o  <= PRIV_M;
        end else if (machine_return_i) begin
            mstatus_mie <= mstatus_mpie;
            privilege_o <= priv_e'(mstatus_mpp);
        end else if (raise_exception_i || interrupt_ack_i) begin
            // Common trap entry
            mstatus_mpp  <= privilege_o;
            privilege_o  <= PRIV_M;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            if (raise_exception_i) begin
                mcause_o <= {1'b0, {(XLEN-6){1'b0}}, exception_code_i};
                if (exception_code_i == ECALL_FROM_MMODE || exception_code_i == BREAKPOINT)
                    mepc_o <= pc_i;                  // Re-execute the trapping instruction
                else
                    mepc_o <= pc_i + 32'd4;
                if (exception_code_i == ILLEGAL_INSTRUCTION)
                    mtval_o <= instruction_i;        // Faulting encoding
                else
                    mtval_o <= pc_i;
            end else begin
                mcause_o <= {1'b1, {(XLEN-6){1'b0}}, irq_code_i};
                // Resume where the interrupted flow was heading
                mepc_o   <= jump_i ? jump_target_i : pc_i;
            end
        end else if (wr_en_i) begin
            case (csr)
                MSTATUS: begin
                    mstatus_mie  <= wr_data_i[MSTATUS_MIE_BIT];
                    mstatus_mpie <= wr_data_i[MSTATUS_MPIE_BIT];
                    mstatus_mpp  <= wr_data_i[MSTATUS_MPP_LSB +: 2];
                end
                MIE:      mie_o      <= wr_data_i;
                MTVEC:    mtvec_o    <= wr_data_i;
                MSCRATCH: mscratch_o <= wr_data_i;
                MEPC:     mepc_o     <= wr_data_i;
                MCAUSE:   mcause_o   <= wr_data_i;
                MTVAL:    mtval_o    <= wr_data_i;
                default:  ;                            // Counters and read-only CSRs
            endcase
        end
    end

endmodule

// ==== rtl/csr_counters.sv ====
// Cycle and retired instruction counters
`timescale 1ns/1ns

module csr_counters (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [11:0]              address_i,
    input  logic [csr_pkg::XLEN-1:0] wr_data_i,
    input  logic                     wr_en_i,
    input  logic                     killed_i,
    output logic [63:0]              mcycle_o,
    output logic [63:0]              minstret_o
);
    import csr_pkg::*;

    csr_addr_e   csr;
    logic [63:0] mcycle_next;
    logic [63:0] minstret_next;

    assign csr = csr_addr_e'(address_i);

    always_comb begin
        mcycle_next   = mcycle_o + 64'd1;
        minstret_next = killed_i ? minstret_o : minstret_o + 64'd1;
        // A written half takes the new data instead of the count
        if (wr_en_i) begin
            case (csr)
                MCYCLE:    mcycle_next[31:0]    = wr_data_i;
                MCYCLEH:   mcycle_next[63:32]   = wr_data_i;
                MINSTRET:  minstret_next[31:0]  = wr_data_i;
                MINSTRETH: minstret_next[63:32] = wr_data_i;
                default:   ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= mcycle_next;
            minstret_o <= minstret_next;
        end
    end

endmodule

// ==== rtl/csr_irq_ctrl.sv ====
// Machine interrupt controller
`timescale 1ns/1ns

module csr_irq_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [csr_pkg::XLEN-1:0] irq_i,
    input  logic [csr_pkg::XLEN-1:0] mie_i,
    input  logic                     mstatus_mie_i,
    input  logic                     interrupt_ack_i,
    output logic [csr_pkg::XLEN-1:0] mip_o,
    output csr_pkg::irq_code_e       irq_code_o,
    output logic                     interrupt_pending_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] enabled;

    assign enabled = mie_i & mip_o;

    // Sampled interrupt lines
    always_ff @(posedge clk) begin
        if (reset)
            mip_o <= '0;
        else
            mip_o <= irq_i;
    end

    ////////////////////////////////////////////////////////////
    // Pending flag and cause
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            interrupt_pending_o <= 1'b0;
            irq_code_o          <= IRQ_NONE;
        end else if (mstatus_mie_i && (enabled != '0) && !interrupt_ack_i) begin
            interrupt_pending_o <= 1'b1;
            if (enabled[11])
                irq_code_o <= M_EXT_INT;   // External wins
            else if (enabled[3])
                irq_code_o <= M_SW_INT;
            else
                irq_code_o <= M_TIM_INT;
        end else begin
            interrupt_pending_o <= 1'b0;   // Cause is held for the acknowledge
        end
    end

endmodule

// ==== rtl/csr_read_mux.sv ====
// CSR read multiplexer
`timescale 1ns/1ns

module csr_read_mux #(
    parameter bit M_EXT = 1'b0
) (
    input  logic [11:0]              address_i,
    input  logic                     read_enable_i,
    input  logic                     killed_i,
    input  logic [csr_pkg::XLEN-1:0] mstatus_i,
    input  logic [csr_pkg::XLEN-1:0] mie_i,
    input  logic [csr_pkg::XLEN-1:0] mtvec_i,
    input  logic [csr_pkg::XLEN-1:0] mscratch_i,
    input  logic [csr_pkg::XLEN-1:0] mepc_i,
    input  logic [csr_pkg::XLEN-1:0] mcause_i,
    input  logic [csr_pkg::XLEN-1:0] mtval_i,
    input  logic [csr_pkg::XLEN-1:0] mip_i,
    input  logic [63:0]              mcycle_i,
    input  logic [63:0]              minstret_i,
    output logic [csr_pkg::XLEN-1:0] data_o,
    output logic [csr_pkg::XLEN-1:0] cur_val_o
);
    import csr_pkg::*;

    // MXL=1, U and I always present, M by parameter
    localparam logic [XLEN-1:0] MISA_VALUE = (32'd1 << 30)
                                           | (32'd1 << 20)
                                           | (32'(M_EXT) << 12)
                                           | (32'd1 << 8);
    localparam logic [XLEN-1:0] ID_VALUE   = '0;   // Vendor, arch, impl and hart

    csr_addr_e csr;

    assign csr = csr_addr_e'(address_i);

    always_comb begin
        case (csr)
            MSTATUS:             cur_val_o = mstatus_i;
            MISA:                cur_val_o = MISA_VALUE;
            MIE:                 cur_val_o = mie_i;
            MTVEC:               cur_val_o = mtvec_i;
            MSCRATCH:            cur_val_o = mscratch_i;
            MEPC:                cur_val_o = mepc_i;
            MCAUSE:              cur_val_o = mcause_i;
            MTVAL:               cur_val_o = mtval_i;
            MIP:                 cur_val_o = mip_i;
            MCYCLE, CYCLE:       cur_val_o = mcycle_i[31:0];
            MCYCLEH, CYCLEH:     cur_val_o = mcycle_i[63:32];
            MINSTRET, INSTRET:   cur_val_o = minstret_i[31:0];
            MINSTRETH, INSTRETH: cur_val_o = minstret_i[63:32];
            MVENDORID, MARCHID,
            MIMPID, MHARTID:     cur_val_o = ID_VALUE;
            default:             cur_val_o = '0;
        endcase
    end

    // Read port only shows data for live reads
    assign data_o = (read_enable_i && !killed_i) ? cur_val_o : '0;

endmodule

// ==== rtl/csr_bank.sv ====
// Machine CSR bank
`timescale 1ns/1ns

module csr_bank #(
    parameter bit M_EXT = 1'b0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     read_enable_i,
    input  logic                     write_enable_i,
    input  csr_pkg::csr_op_e         operation_i,
    input  logic [11:0]              address_i,
    input  logic [csr_pkg::XLEN-1:0] data_i,
    input  logic                     killed_i,
    output logic [csr_pkg::XLEN-1:0] data_o,
    input  logic                     raise_exception_i,
    input  logic                     machine_return_i,
    input  csr_pkg::exc_code_e       exception_code_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic [csr_pkg::XLEN-1:0] instruction_i,
    input  logic                     jump_i,
    input  logic [csr_pkg::XLEN-1:0] jump_target_i,
    input  logic [csr_pkg::XLEN-1:0] irq_i,
    input  logic                     interrupt_ack_i,
    output logic                     interrupt_pending_o,
    output csr_pkg::priv_e           privilege_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic [csr_pkg::XLEN-1:0] mtvec_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] cur_val;
    logic [XLEN-1:0] wr_data;
    logic            wr_en;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mip;
    logic            mstatus_mie;
    irq_code_e       irq_code;
    logic [63:0]     mcycle;
    logic [63:0]     minstret;

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    csr_wdata u_wdata (
        .address_i         (address_i),
        .operation_i       (operation_i),
        .data_i            (data_i),
        .cur_val_i         (cur_val),
        .write_enable_i    (write_enable_i),
        .killed_i          (killed_i),
        .machine_return_i  (machine_return_i),
        .raise_exception_i (raise_exception_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .wr_data_o         (wr_data),
        .wr_en_o           (wr_en)
    );

    csr_trap_regs u_trap_regs (
        .clk               (clk),
        .reset             (reset),
        .address_i         (address_i),
        .wr_data_i         (wr_data),
        .wr_en_i           (wr_en),
        .machine_return_i  (machine_return_i),
        .raise_exception_i (raise_exception_i),
        .exception_code_i  (exception_code_i),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .jump_i            (jump_i),
        .jump_target_i     (jump_target_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .irq_code_i        (irq_code),
        .mstatus_o         (mstatus),
        .mie_o             (mie),
        .mtvec_o           (mtvec_o),
        .mscratch_o        (mscratch),
        .mepc_o            (mepc_o),
        .mcause_o          (mcause),
        .mtval_o           (mtval),
        .privilege_o       (privilege_o),
        .mstatus_mie_o     (mstatus_mie)
    );

    csr_counters u_counters (
        .clk        (clk),
        .reset      (reset),
        .address_i  (address_i),
        .wr_data_i  (wr_data),
        .wr_en_i    (wr_en),
        .killed_i   (killed_i),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_irq_ctrl u_irq_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .irq_i               (irq_i),
        .mie_i               (mie),
        .mstatus_mie_i       (mstatus_mie),
        .interrupt_ack_i     (interrupt_ack_i),
        .mip_o               (mip),
        .irq_code_o          (irq_code),
        .interrupt_pending_o (interrupt_pending_o)
    );

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    csr_read_mux #(
        .M_EXT (M_EXT)
    ) u_read_mux (
        .address_i     (address_i),
        .read_enable_i (read_enable_i),
        .killed_i      (killed_i),
        .mstatus_i     (mstatus),
        .mie_i         (mie),
        .mtvec_i       (mtvec_o),
        .mscratch_i    (mscratch),
        .mepc_i        (mepc_o),
        .mcause_i      (mcause),
        .mtval_i       (mtval),
        .mip_i         (mip),
        .mcycle_i      (mcycle),
        .minstret_i    (minstret),
        .data_o        (data_o),
        .cur_val_o     (cur_val)    // Feeds set and clear
    );

endmodule

// ==== verification/csr_bank_asserts.sv ====
// CSR bank assertions
`timescale 1ns/1ns

module csr_bank_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     read_enable_i,
    input logic                     raise_exception_i,
    input logic                     machine_return_i,
    input logic                     interrupt_ack_i,
    input logic                     interrupt_pending_i,
    input logic [csr_pkg::XLEN-1:0] data_i,
    input csr_pkg::priv_e           privilege_i
);
    import csr_pkg::*;

    int unsigned fail_count = 0;    // Failed assertion count

    pending_in_reset: assert property (@(posedge clk) reset |=> !interrupt_pending_i)
        else begin
            fail_count++;
            $error("interrupt_pending_o high after a reset cycle");
        end

    // Acknowledge always drops the flag
    pending_after_ack: assert property (@(posedge clk) disable iff (reset)
        interrupt_ack_i |=> !interrupt_pending_i)
        else begin
            fail_count++;
            $error("interrupt_pending_o still high after acknowledge");
        end

    read_gated: assert property (@(posedge clk) !read_enable_i |-> data_i == '0)
        else begin
            fail_count++;
            $error("data_o nonzero with read enable low");
        end

    priv_after_trap: assert property (@(posedge clk) disable iff (reset)
        raise_exception_i && !machine_return_i |=> privilege_i == PRIV_M)
        else begin
            fail_count++;
            $error("privilege_o not machine mode after exception");
        end

endmodule

bind csr_bank csr_bank_asserts u_asserts (
    .clk                 (clk),
    .reset               (reset),
    .read_enable_i       (read_enable_i),
    .raise_exception_i   (raise_exception_i),
    .machine_return_i    (machine_return_i),
    .interrupt_ack_i     (interrupt_ack_i),
    .interrupt_pending_i (interrupt_pending_o),
    .data_i              (data_o),
    .privilege_i         (privilege_o)
);

// ==== verification/csr_bank_tb.sv ====
// CSR bank testbench
`timescale 1ns/1ns

module csr_bank_tb;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS     = 14;
    localparam int PEND_TIMEOUT = 20;   // Cycles allowed for pending to rise
    localparam int CYCLE_GAP    = 7;
    localparam int KILL_CYCLES  = 5;

    logic        clk = 1'b0;
    logic        reset;
    logic        read_enable;
    logic        write_enable;
    csr_op_e     operation;
    logic [11:0] address;
    logic [31:0] data_in;
    logic        killed;
    logic [31:0] data_out;
    logic        raise_exception;
    logic        machine_return;
    exc_code_e   exception_code;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic        jump;
    logic [31:0] jump_target;
    logic [31:0] irq;
    logic        interrupt_ack;
    logic        interrupt_pending;
    priv_e       privilege;
    logic [31:0] mepc_out;
    logic [31:0] mtvec_out;

    // Stimulus table with one row per CSR operation
    csr_op_e     row_op   [NUM_ROWS];
    logic [11:0] row_addr [NUM_ROWS];
    logic [31:0] row_data [NUM_ROWS];
    logic        row_kill [NUM_ROWS];
    logic [31:0] row_exp  [NUM_ROWS];
    logic [31:0] shadow   [4096];       // Expected contents by address
    int          n_rows;

    int          errors;
    int          errors_at_start;
    int          tests;
    int          failed_tests;
    int          waited;
    logic [31:0] pc_val;
    logic [31:0] instr_val;
    logic [31:0] first;
    logic [31:0] second;

    csr_bank #(
        .M_EXT (1'b1)
    ) UUT (
        .clk                 (clk),
        .reset               (reset),
        .read_enable_i       (read_enable),
        .write_enable_i      (write_enable),
        .operation_i         (operation),
        .address_i           (address),
        .data_i              (data_in),
        .killed_i            (killed),
        .data_o              (data_out),
        .raise_exception_i   (raise_exception),
        .machine_return_i    (machine_return),
        .exception_code_i    (exception_code),
        .pc_i                (pc),
        .instruction_i       (instruction),
        .jump_i              (jump),
        .jump_target_i       (jump_target),
        .irq_i               (irq),
        .interrupt_ack_i     (interrupt_ack),
        .interrupt_pending_o (interrupt_pending),
        .privilege_o         (privilege),
        .mepc_o              (mepc_out),
        .mtvec_o             (mtvec_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] mask_of(input logic [11:0] addr);
        case (addr)
            MSTATUS:  return 32'h0000_1888;     // MIE, MPIE, MPP
            MIE:      return 32'h0000_0888;
            MTVEC,
            MEPC:     return 32'hFFFF_FFFC;
            MSCRATCH: return 32'hFFFF_FFFF;
            default:  return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [31:0] status_word(input logic [1:0] mpp, input logic mpie,
                                                input logic mie);
        return {19'd0, mpp, 3'd0, mpie, 3'd0, mie, 3'd0};
    endfunction

    task automatic add_row(input csr_op_e op, input logic [11:0] addr, input logic kill);
        logic [31:0] value;
        logic [31:0] result;
        value = $urandom;
        case (op)
            SET:     result = (shadow[addr] | value) & mask_of(addr);
            CLEAR:   result = (shadow[addr] & ~value) & mask_of(addr);
            default: result = value & mask_of(addr);
        endcase
        if (!kill)
            shadow[addr] = result;              // Killed writes leave the CSR alone
        row_op[n_rows]   = op;
        row_addr[n_rows] = addr;
        row_data[n_rows] = value;
        row_kill[n_rows] = kill;
        row_exp[n_rows]  = shadow[addr];
        n_rows++;
    endtask

    ////////////////////////////////////////////////////////////
    // Drivers and checks
    ////////////////////////////////////////////////////////////

    task automatic set_idle();
        read_enable     = 1'b0;
        write_enable    = 1'b0;
        operation       = WRITE;
        address         = '0;
        data_in         = '0;
        killed          = 1'b0;
        raise_exception = 1'b0;
        machine_return  = 1'b0;
        exception_code  = ILLEGAL_INSTRUCTION;
        pc              = '0;
        instruction     = '0;
        jump            = 1'b0;
        jump_target     = '0;
        interrupt_ack   = 1'b0;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic csr_op(input csr_op_e op, input logic [11:0] addr,
                          input logic [31:0] value, input logic kill);
        @(negedge clk);
        set_idle();
        write_enable = 1'b1;
        operation    = op;
        address      = addr;
        data_in      = value;
        killed       = kill;
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] value);
        @(negedge clk);
        set_idle();
        read_enable = 1'b1;
        address     = addr;
        #(CLK_PERIOD / 4);                      // Mid low phase
        value = data_out;
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] value;
        read_csr(addr, value);
        compare($sformatf("data_o[%h]", addr), value, exp);
    endtask

    task automatic take_exception(input exc_code_e code, input logic [31:0] at_pc,
                                  input logic [31:0] instr);
        @(negedge clk);
        set_idle();
        raise_exception = 1'b1;
        exception_code  = code;
        pc              = at_pc;
        instruction     = instr;
    endtask

    task automatic trap_return();
        @(negedge clk);
        set_idle();
        machine_return = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            set_idle();
        end
    endtask

    task automatic hold_killed(input int n);
        repeat (n) begin
            @(negedge clk);
            set_idle();
            killed = 1'b1;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s FAILED with %0d errors", name, errors - errors_at_start);
            failed_tests++;
        end
        tests++;
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hcc6e_883b));
        errors          = 0;
        errors_at_start = 0;
        tests           = 0;
        failed_tests    = 0;
        n_rows          = 0;
        irq             = '0;
        reset           = 1'b1;
        set_idle();
        foreach (shadow[k])
            shadow[k] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // MXL 1 with I, M and U
        check_read(MISA, 32'h4010_1100);
        check_read(MSTATUS, '0);
        check_read(MTVEC, '0);
        check_read(MIE, '0);
        check_read(MCAUSE, '0);
        check_read(MIP, '0);
        check_read(MVENDORID, '0);
        check_read(MARCHID, '0);
        check_read(MIMPID, '0);
        check_read(MHARTID, '0);
        compare("privilege_o", 32'(privilege), 32'd3);      // Machine mode
        compare("interrupt_pending_o", 32'(interrupt_pending), 32'd0);
        end_test("reset_values");

        add_row(WRITE, MSCRATCH, 1'b0);
        add_row(SET, MSCRATCH, 1'b0);
        add_row(CLEAR, MSCRATCH, 1'b0);
        add_row(WRITE, MSCRATCH, 1'b1);
        add_row(WRITE, MTVEC, 1'b0);
        add_row(SET, MTVEC, 1'b0);
        add_row(CLEAR, MTVEC, 1'b0);
        add_row(WRITE, MIE, 1'b0);
        add_row(SET, MIE, 1'b0);
        add_row(CLEAR, MIE, 1'b1);
        add_row(CLEAR, MIE, 1'b0);
        add_row(WRITE, MSTATUS, 1'b0);
        add_row(SET, MSTATUS, 1'b0);
        add_row(CLEAR, MSTATUS, 1'b0);
        for (int i = 0; i < n_rows; i++) begin
            csr_op(row_op[i], row_addr[i], row_data[i], row_kill[i]);
            check_read(row_addr[i], row_exp[i]);
        end
        compare("mtvec_o", mtvec_out, shadow[MTVEC]);
        @(negedge clk);
        set_idle();
        address = MSCRATCH;                     // Read enable stays low
        #(CLK_PERIOD / 4);
        compare("data_o", data_out, '0);
        end_test("csr_table");

        csr_op(WRITE, MSTATUS, status_word(2'b00, 1'b0, 1'b1), 1'b0);
        pc_val    = $urandom & 32'hFFFF_FFFC;
        instr_val = $urandom;
        take_exception(ILLEGAL_INSTRUCTION, pc_val, instr_val);
        check_read(MCAUSE, 32'd2);
        check_read(MEPC, pc_val + 32'd4);
        compare("mepc_o", mepc_out, pc_val + 32'd4);
        check_read(MTVAL, instr_val);
        check_read(MSTATUS, status_word(2'b11, 1'b1, 1'b0));
        trap_return();
        check_read(MSTATUS, status_word(2'b11, 1'b1, 1'b1));
        compare("privilege_o", 32'(privilege), 32'd3);      // Earlier MPP
        // Second return drops to user mode
        csr_op(WRITE, MSTATUS, status_word(2'b00, 1'b1, 1'b0), 1'b0);
        trap_return();
        check_read(MSTATUS, status_word(2'b00, 1'b1, 1'b1));
        compare("privilege_o", 32'(privilege), 32'd0);
        end_test("illegal_mret");

        pc_val = $urandom & 32'hFFFF_FFFC;
        take_exception(ECALL_FROM_MMODE, pc_val, $urandom);
        check_read(MCAUSE, 32'd11);
        check_read(MEPC, pc_val);
        check_read(MTVAL, pc_val);
        check_read(MSTATUS, status_word(2'b00, 1'b1, 1'b0));
        compare("privilege_o", 32'(privilege), 32'd3);
        end_test("ecall");

        csr_op(WRITE, MSTATUS, status_word(2'b00, 1'b0, 1'b1), 1'b0);
        csr_op(WRITE, MIE, 32'h0000_0800, 1'b0);
        @(negedge clk);
        set_idle();
        irq    = 32'h0000_0800;                 // External line
        waited = 0;
        while (!interrupt_pending && waited < PEND_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!interrupt_pending) begin
            $display("Timeout: interrupt_pending_o did not rise after %0d cycles", waited);
            errors++;
        end
        pc_val = $urandom & 32'hFFFF_FFFC;
        @(negedge clk);
        set_idle();
        interrupt_ack = 1'b1;
        jump          = 1'b1;
        jump_target   = pc_val;
        pc            = pc_val + 32'd8;
        irq           = '0;
        check_read(MCAUSE, 32'h8000_000B);
        compare("interrupt_pending_o", 32'(interrupt_pending), 32'd0);
        check_read(MEPC, pc_val);
        check_read(MSTATUS, status_word(2'b11, 1'b1, 1'b0));
        end_test("interrupt");

        read_csr(MCYCLE, first);
        idle_cycles(CYCLE_GAP - 1);
        read_csr(CYCLE, second);
        compare("mcycle delta", second - first, 32'(CYCLE_GAP));
        pc_val = $urandom;
        csr_op(WRITE, MINSTRETH, pc_val, 1'b0);
        check_read(MINSTRETH, pc_val);
        check_read(INSTRETH, pc_val);
        read_csr(MINSTRET, first);
        hold_killed(KILL_CYCLES);
        read_csr(INSTRET, second);
        // Only the first read cycle retires
        compare("minstret", second, first + 32'd1);
        end_test("counters");

        errors += UUT.u_asserts.fail_count;
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/csr_pkg.sv
rtl/csr_wdata.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/csr_irq_ctrl.sv
rtl/csr_read_mux.sv
rtl/csr_bank.sv
verification/csr_bank_asserts.sv
verification/csr_bank_tb.sv

// ==== Makefile ====
# Verilator flow for the CSR bank

VERILATOR ?= verilator
TOP       ?= csr_bank_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
